// File: src/wm_pkg.sv
package wm_pkg;

  //////////////////////////////////////////////////////////////////////////
  // axi4 protocol limits
  //////////////////////////////////////////////////////////////////////////

  // longest burst the protocol allows, in beats
  localparam int AXI_MAX_BURST_BEATS = 256;

  // no burst may cross this byte boundary
  localparam int AXI_MAX_BURST_BYTES = 4096;

  //////////////////////////////////////////////////////////////////////////
  // transfer control states
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // waiting for a queued command
    IDLE,
    // command registered, plan being computed
    LOAD,
    // bursts in flight
    RUN,
    // final response received
    FINISH
  } xfer_state_t;

endpackage

// File: src/wm_counter.sv
`timescale 1ns/100ps

module wm_counter #(
  parameter int               WIDTH = 8,
  parameter logic [WIDTH-1:0] INIT  = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [WIDTH-1:0] load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  // load has priority over counting
  // incr and decr in the same cycle leave the count alone
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= INIT;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
  end

  assign is_zero = (count == '0);

endmodule

// File: src/cmd_queue.sv
`timescale 1ns/100ps

module cmd_queue #(
  parameter int ADDR_WIDTH    = 32,
  parameter int CMD_DEPTH_LOG = 3
) (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  ctrl_start,
  input  logic [ADDR_WIDTH-1:0] ctrl_addr,
  input  logic [ADDR_WIDTH-1:0] ctrl_size,
  input  logic                  cmd_pop,
  output logic                  cmd_valid,
  output logic [ADDR_WIDTH-1:0] cmd_addr,
  output logic [ADDR_WIDTH-1:0] cmd_size,
  output logic                  req_almost_full
);

  localparam int DEPTH = 1 << CMD_DEPTH_LOG;
  localparam logic [CMD_DEPTH_LOG:0] FULL_FILL   = (CMD_DEPTH_LOG + 1)'(DEPTH);
  localparam logic [CMD_DEPTH_LOG:0] ALMOST_FILL = (CMD_DEPTH_LOG + 1)'(DEPTH - 1);

  // address and size storage
  logic [ADDR_WIDTH-1:0]    addr_mem [DEPTH];
  logic [ADDR_WIDTH-1:0]    size_mem [DEPTH];
  logic [CMD_DEPTH_LOG-1:0] wr_ptr;
  logic [CMD_DEPTH_LOG-1:0] rd_ptr;
  logic [CMD_DEPTH_LOG:0]   fill;
  logic                     push;
  logic                     pop;

  // a start while full is dropped
  assign push = ctrl_start && (fill != FULL_FILL);
  assign pop  = cmd_pop && cmd_valid;

  always_ff @(posedge aclk) begin
    if (push) begin
      addr_mem[wr_ptr] <= ctrl_addr;
      size_mem[wr_ptr] <= ctrl_size;
    end
  end

  // pointers wrap on their own width
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      wr_ptr <= wr_ptr + CMD_DEPTH_LOG'(push);
      rd_ptr <= rd_ptr + CMD_DEPTH_LOG'(pop);
      fill   <= fill + (CMD_DEPTH_LOG + 1)'(push) - (CMD_DEPTH_LOG + 1)'(pop);
    end
  end

  // head of queue shows directly
  assign cmd_valid       = (fill != '0);
  assign cmd_addr        = addr_mem[rd_ptr];
  assign cmd_size        = size_mem[rd_ptr];
  // one slot or fewer left
  assign req_almost_full = (fill >= ALMOST_FILL);

endmodule

// File: src/xfer_control.sv
`timescale 1ns/100ps

module xfer_control #(
  parameter int  ADDR_WIDTH  = 32,
  parameter int  DATA_WIDTH  = 32,
  localparam int BEAT_BYTES  = DATA_WIDTH / 8,
  localparam int LOG_BYTES   = $clog2(BEAT_BYTES),
  localparam int BURST_BEATS =
    (wm_pkg::AXI_MAX_BURST_BYTES / BEAT_BYTES < wm_pkg::AXI_MAX_BURST_BEATS) ?
    wm_pkg::AXI_MAX_BURST_BYTES / BEAT_BYTES : wm_pkg::AXI_MAX_BURST_BEATS,
  localparam int LOG_BURST   = $clog2(BURST_BEATS),
  localparam int TOTAL_W     = ADDR_WIDTH - LOG_BYTES,
  localparam int BURST_CNT_W = TOTAL_W - LOG_BURST
) (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   cmd_valid,
  input  logic [ADDR_WIDTH-1:0]  cmd_addr,
  input  logic [ADDR_WIDTH-1:0]  cmd_size,
  output logic                   cmd_pop,
  input  logic                   m_axi_bvalid,
  output logic                   burst_start,
  output logic                   running,
  input  logic                   final_beat,
  output logic [ADDR_WIDTH-1:0]  addr_base,
  output logic [BURST_CNT_W-1:0] num_bursts,
  output logic [7:0]             last_len,
  output logic [BEAT_BYTES-1:0]  last_strb,
  output logic                   ctrl_done
);

  wm_pkg::xfer_state_t   state;
  wm_pkg::xfer_state_t   state_next;
  logic [ADDR_WIDTH-1:0] size_r;
  logic [LOG_BYTES-1:0]  rem;
  logic [TOTAL_W-1:0]    beats_m1;
  logic [BEAT_BYTES-1:0] strb_calc;
  logic                  resp_final;
  logic                  last_resp;

  //////////////////////////////////////////////////////////////////////////
  // command fsm
  //////////////////////////////////////////////////////////////////////////

  // only pop while idle and something is queued
  assign cmd_pop   = (state == wm_pkg::IDLE) && cmd_valid;
  assign last_resp = (state == wm_pkg::RUN) && m_axi_bvalid && resp_final;
  // done pulse is the single FINISH cycle
  assign ctrl_done = (state == wm_pkg::FINISH);

  always_comb begin
    state_next = state;
    case (state)
      wm_pkg::IDLE: begin
        if (cmd_valid) begin
          state_next = wm_pkg::LOAD;
        end
      end
      wm_pkg::LOAD: begin
        state_next = wm_pkg::RUN;
      end
      wm_pkg::RUN: begin
        if (last_resp) begin
          state_next = wm_pkg::FINISH;
        end
      end
      default: begin
        state_next = wm_pkg::IDLE;
      end
    endcase
  end

  // burst_start marks the first RUN cycle and running follows it
  always_ff @(posedge aclk) begin
    if (areset) begin
      state       <= wm_pkg::IDLE;
      burst_start <= 1'b0;
      running     <= 1'b0;
    end else begin
      state       <= state_next;
      burst_start <= (state == wm_pkg::LOAD);
      running     <= burst_start || (running && !final_beat);
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // burst plan
  //////////////////////////////////////////////////////////////////////////

  // bytes hanging over the last whole beat
  assign rem = size_r[LOG_BYTES-1:0];

  // total beats minus one, rounded up to whole beats
  assign beats_m1 = (rem != '0) ? size_r[ADDR_WIDTH-1:LOG_BYTES] :
                                  size_r[ADDR_WIDTH-1:LOG_BYTES] - 1'b1;

  // final beat strobe, all ones when the size fills the beat
  always_comb begin
    for (int i = 0; i < BEAT_BYTES; i++) begin
      strb_calc[i] = (rem == '0) || (i < int'(rem));
    end
  end

  always_ff @(posedge aclk) begin
    if (cmd_pop) begin
      addr_base <= cmd_addr;
      size_r    <= cmd_size;
    end
    if (state == wm_pkg::LOAD) begin
      // upper bits count the full bursts after the first
      num_bursts <= beats_m1[TOTAL_W-1:LOG_BURST];
      last_len   <= 8'(beats_m1[LOG_BURST-1:0]);
      last_strb  <= strb_calc;
    end
  end

  // responses still owed, zero once only the last is pending
  wm_counter #(
    .WIDTH (BURST_CNT_W),
    .INIT  ('0)
  ) resp_cnt_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (state == wm_pkg::LOAD),
    .incr       (1'b0),
    .decr       (m_axi_bvalid),
    .load_value (beats_m1[TOTAL_W-1:LOG_BURST]),
    .count      (),
    .is_zero    (resp_final)
  );

endmodule

// File: src/aw_channel.sv
`timescale 1ns/100ps

module aw_channel #(
  parameter int  ADDR_WIDTH      = 32,
  parameter int  DATA_WIDTH      = 32,
  parameter int  MAX_OUTSTANDING = 8,
  localparam int BEAT_BYTES      = DATA_WIDTH / 8,
  localparam int LOG_BYTES       = $clog2(BEAT_BYTES),
  localparam int BURST_BEATS     =
    (wm_pkg::AXI_MAX_BURST_BYTES / BEAT_BYTES < wm_pkg::AXI_MAX_BURST_BEATS) ?
    wm_pkg::AXI_MAX_BURST_BYTES / BEAT_BYTES : wm_pkg::AXI_MAX_BURST_BEATS,
  localparam int LOG_BURST       = $clog2(BURST_BEATS),
  localparam int BURST_CNT_W     = ADDR_WIDTH - LOG_BYTES - LOG_BURST
) (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   burst_start,
  input  logic [ADDR_WIDTH-1:0]  addr_base,
  input  logic [BURST_CNT_W-1:0] num_bursts,
  input  logic [7:0]             last_len,
  input  logic                   first_beat_seen,
  input  logic                   m_axi_bvalid,
  input  logic                   m_axi_awready,
  output logic                   m_axi_awvalid,
  output logic [ADDR_WIDTH-1:0]  m_axi_awaddr,
  output logic [7:0]             m_axi_awlen
);

  localparam int VAC_W = $clog2(MAX_OUTSTANDING + 1);
  localparam logic [ADDR_WIDTH-1:0] BURST_BYTES = ADDR_WIDTH'(BEAT_BYTES * BURST_BEATS);
  localparam logic [7:0] FULL_LEN = 8'(BURST_BEATS - 1);

  logic awvalid_r;
  logic awxfer;
  logic aw_final;
  logic data_idle;
  logic stall;

  assign m_axi_awvalid = awvalid_r;
  assign awxfer        = awvalid_r && m_axi_awready;
  // only the final burst of a command is short
  assign m_axi_awlen   = aw_final ? last_len : FULL_LEN;

  // raise when a burst has data on the way and a response slot is free
  // hold until awready
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid_r <= 1'b0;
    end else if (!awvalid_r) begin
      awvalid_r <= !data_idle && !stall;
    end else if (m_axi_awready) begin
      awvalid_r <= 1'b0;
    end
  end

  // step one full burst per accepted address
  always_ff @(posedge aclk) begin
    if (burst_start) begin
      m_axi_awaddr <= addr_base;
    end else if (awxfer) begin
      m_axi_awaddr <= m_axi_awaddr + BURST_BYTES;
    end
  end

  // addresses left after the current one
  wm_counter #(
    .WIDTH (BURST_CNT_W),
    .INIT  ('0)
  ) aw_todo_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (burst_start),
    .incr       (1'b0),
    .decr       (awxfer),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (aw_final)
  );

  // data bursts started but not yet addressed
  wm_counter #(
    .WIDTH (BURST_CNT_W + 1),
    .INIT  ('0)
  ) data_ahead_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (first_beat_seen),
    .decr       (awxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (data_idle)
  );

  // free response slots
  wm_counter #(
    .WIDTH (VAC_W),
    .INIT  (VAC_W'(MAX_OUTSTANDING))
  ) vacancy_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (m_axi_bvalid),
    .decr       (awxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (stall)
  );

endmodule

// File: src/w_channel.sv
`timescale 1ns/100ps

module w_channel #(
  parameter int  ADDR_WIDTH  = 32,
  parameter int  DATA_WIDTH  = 32,
  localparam int BEAT_BYTES  = DATA_WIDTH / 8,
  localparam int LOG_BYTES   = $clog2(BEAT_BYTES),
  localparam int BURST_BEATS =
    (wm_pkg::AXI_MAX_BURST_BYTES / BEAT_BYTES < wm_pkg::AXI_MAX_BURST_BEATS) ?
    wm_pkg::AXI_MAX_BURST_BYTES / BEAT_BYTES : wm_pkg::AXI_MAX_BURST_BEATS,
  localparam int LOG_BURST   = $clog2(BURST_BEATS),
  localparam int BURST_CNT_W = ADDR_WIDTH - LOG_BYTES - LOG_BURST
) (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   running,
  input  logic                   burst_start,
  input  logic [BURST_CNT_W-1:0] num_bursts,
  input  logic [7:0]             last_len,
  input  logic [BEAT_BYTES-1:0]  last_strb,
  input  logic                   s_axis_tvalid,
  input  logic [DATA_WIDTH-1:0]  s_axis_tdata,
  output logic                   s_axis_tready,
  input  logic                   m_axi_wready,
  output logic                   m_axi_wvalid,
  output logic [DATA_WIDTH-1:0]  m_axi_wdata,
  output logic [BEAT_BYTES-1:0]  m_axi_wstrb,
  output logic                   m_axi_wlast,
  output logic                   wxfer,
  output logic                   first_beat_seen,
  output logic                   final_beat
);

  // beats per burst is a power of two so its awlen is all ones
  localparam logic [LOG_BURST-1:0] FULL_LEN = '1;

  logic [BURST_CNT_W-1:0] bursts_to_go;
  logic                   final_burst;
  logic                   burst_end;
  logic                   next_is_final;
  logic [LOG_BURST-1:0]   beat_value;
  logic                   need_flag;
  logic                   flag_now;

  //////////////////////////////////////////////////////////////////////////
  // stream pass-through
  //////////////////////////////////////////////////////////////////////////

  // no buffering, wready stalls the stream directly
  assign m_axi_wvalid  = s_axis_tvalid && running;
  assign s_axis_tready = m_axi_wready && running;
  assign m_axi_wdata   = s_axis_tdata;

  assign wxfer       = m_axi_wvalid && m_axi_wready;
  assign burst_end   = wxfer && m_axi_wlast;
  assign final_beat  = burst_end && final_burst;
  // partial strobe on the last beat of the command only
  assign m_axi_wstrb = (m_axi_wlast && final_burst) ? last_strb : '1;

  //////////////////////////////////////////////////////////////////////////
  // burst framing
  //////////////////////////////////////////////////////////////////////////

  // length of the burst about to begin
  assign next_is_final = burst_start ? (num_bursts == '0) :
                                       (bursts_to_go == BURST_CNT_W'(1));
  assign beat_value    = next_is_final ? last_len[LOG_BURST-1:0] : FULL_LEN;

  // beats left in the burst, wlast when zero
  wm_counter #(
    .WIDTH (LOG_BURST),
    .INIT  ('1)
  ) beat_cnt_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (burst_start || burst_end),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (beat_value),
    .count      (),
    .is_zero    (m_axi_wlast)
  );

  // bursts left after the current one
  wm_counter #(
    .WIDTH (BURST_CNT_W),
    .INIT  ('0)
  ) burst_cnt_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (burst_start),
    .incr       (1'b0),
    .decr       (burst_end),
    .load_value (num_bursts),
    .count      (bursts_to_go),
    .is_zero    (final_burst)
  );

  // one pulse per burst when its first beat is offered
  // stream gaps before the handshake do not pulse again
  assign flag_now = m_axi_wvalid && need_flag;

  always_ff @(posedge aclk) begin
    if (areset) begin
      need_flag       <= 1'b1;
      first_beat_seen <= 1'b0;
    end else begin
      first_beat_seen <= flag_now;
      if (burst_end) begin
        need_flag <= 1'b1;
      end else if (flag_now) begin
        need_flag <= 1'b0;
      end
    end
  end

endmodule

// File: src/wr_master_top.sv
`timescale 1ns/100ps

module wr_master_top #(
  parameter int  ADDR_WIDTH      = 32,
  parameter int  DATA_WIDTH      = 32,
  parameter int  MAX_OUTSTANDING = 8,
  parameter int  CMD_DEPTH_LOG   = 3,
  localparam int BEAT_BYTES      = DATA_WIDTH / 8,
  localparam int BURST_BEATS     =
    (wm_pkg::AXI_MAX_BURST_BYTES / BEAT_BYTES < wm_pkg::AXI_MAX_BURST_BEATS) ?
    wm_pkg::AXI_MAX_BURST_BYTES / BEAT_BYTES : wm_pkg::AXI_MAX_BURST_BEATS,
  localparam int BURST_CNT_W     =
    ADDR_WIDTH - $clog2(BEAT_BYTES) - $clog2(BURST_BEATS)
) (
  input  logic                  aclk,
  input  logic                  areset,
  // host command side
  input  logic                  ctrl_start,
  input  logic [ADDR_WIDTH-1:0] ctrl_addr,
  input  logic [ADDR_WIDTH-1:0] ctrl_size,
  output logic                  ctrl_done,
  output logic                  req_almost_full,
  // write data stream
  input  logic                  s_axis_tvalid,
  input  logic [DATA_WIDTH-1:0] s_axis_tdata,
  output logic                  s_axis_tready,
  // axi write address
  output logic                  m_axi_awvalid,
  input  logic                  m_axi_awready,
  output logic [ADDR_WIDTH-1:0] m_axi_awaddr,
  output logic [7:0]            m_axi_awlen,
  // axi write data
  output logic                  m_axi_wvalid,
  input  logic                  m_axi_wready,
  output logic [DATA_WIDTH-1:0] m_axi_wdata,
  output logic [BEAT_BYTES-1:0] m_axi_wstrb,
  output logic                  m_axi_wlast,
  // axi write response
  input  logic                  m_axi_bvalid,
  output logic                  m_axi_bready
);

  logic                   cmd_valid;
  logic [ADDR_WIDTH-1:0]  cmd_addr;
  logic [ADDR_WIDTH-1:0]  cmd_size;
  logic                   cmd_pop;
  logic                   burst_start;
  logic                   running;
  logic [ADDR_WIDTH-1:0]  addr_base;
  logic [BURST_CNT_W-1:0] num_bursts;
  logic [7:0]             last_len;
  logic [BEAT_BYTES-1:0]  last_strb;
  // data channel progress
  logic                   first_beat_seen;
  logic                   final_beat;

  // responses are always accepted
  assign m_axi_bready = 1'b1;

  cmd_queue #(
    .ADDR_WIDTH    (ADDR_WIDTH),
    .CMD_DEPTH_LOG (CMD_DEPTH_LOG)
  ) cmd_queue_i (
    .aclk            (aclk),
    .areset          (areset),
    .ctrl_start      (ctrl_start),
    .ctrl_addr       (ctrl_addr),
    .ctrl_size       (ctrl_size),
    .cmd_pop         (cmd_pop),
    .cmd_valid       (cmd_valid),
    .cmd_addr        (cmd_addr),
    .cmd_size        (cmd_size),
    .req_almost_full (req_almost_full)
  );

  xfer_control #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) xfer_control_i (
    .aclk         (aclk),
    .areset       (areset),
    .cmd_valid    (cmd_valid),
    .cmd_addr     (cmd_addr),
    .cmd_size     (cmd_size),
    .cmd_pop      (cmd_pop),
    .m_axi_bvalid (m_axi_bvalid),
    .burst_start  (burst_start),
    .running      (running),
    .final_beat   (final_beat),
    .addr_base    (addr_base),
    .num_bursts   (num_bursts),
    .last_len     (last_len),
    .last_strb    (last_strb),
    .ctrl_done    (ctrl_done)
  );

  aw_channel #(
    .ADDR_WIDTH      (ADDR_WIDTH),
    .DATA_WIDTH      (DATA_WIDTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) aw_channel_i (
    .aclk            (aclk),
    .areset          (areset),
    .burst_start     (burst_start),
    .addr_base       (addr_base),
    .num_bursts      (num_bursts),
    .last_len        (last_len),
    .first_beat_seen (first_beat_seen),
    .m_axi_bvalid    (m_axi_bvalid),
    .m_axi_awready   (m_axi_awready),
    .m_axi_awvalid   (m_axi_awvalid),
    .m_axi_awaddr    (m_axi_awaddr),
    .m_axi_awlen     (m_axi_awlen)
  );

  w_channel #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) w_channel_i (
    .aclk            (aclk),
    .areset          (areset),
    .running         (running),
    .burst_start     (burst_start),
    .num_bursts      (num_bursts),
    .last_len        (last_len),
    .last_strb       (last_strb),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tdata    (s_axis_tdata),
    .s_axis_tready   (s_axis_tready),
    .m_axi_wready    (m_axi_wready),
    .m_axi_wvalid    (m_axi_wvalid),
    .m_axi_wdata     (m_axi_wdata),
    .m_axi_wstrb     (m_axi_wstrb),
    .m_axi_wlast     (m_axi_wlast),
    .wxfer           (),
    .first_beat_seen (first_beat_seen),
    .final_beat      (final_beat)
  );

endmodule

// File: bench/wr_master_asserts.sv
`timescale 1ns/100ps

module wr_master_asserts #(
  parameter int ADDR_WIDTH = 32
) (
  input logic                  aclk,
  input logic                  areset,
  input logic                  m_axi_awvalid,
  input logic                  m_axi_awready,
  input logic [ADDR_WIDTH-1:0] m_axi_awaddr,
  input logic [7:0]            m_axi_awlen,
  input logic                  m_axi_wvalid,
  input logic                  s_axis_tready,
  input logic                  running,
  input logic                  ctrl_done
);

  // address channel holds its request until accepted
  aw_hold_a : assert property (@(posedge aclk) disable iff (areset)
    (m_axi_awvalid && !m_axi_awready) |=>
      (m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen)))
    else $error("awvalid dropped or address changed before awready");

  // data is only offered while a command runs
  w_gate_a : assert property (@(posedge aclk) disable iff (areset)
    !($rose(m_axi_wvalid) && !s_axis_tready && !running))
    else $error("wvalid rose while not running");

  // single cycle done pulse
  done_pulse_a : assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
    else $error("ctrl_done longer than one cycle");

endmodule

bind wr_master_top wr_master_asserts #(
  .ADDR_WIDTH (ADDR_WIDTH)
) asserts_i (
  .aclk          (aclk),
  .areset        (areset),
  .m_axi_awvalid (m_axi_awvalid),
  .m_axi_awready (m_axi_awready),
  .m_axi_awaddr  (m_axi_awaddr),
  .m_axi_awlen   (m_axi_awlen),
  .m_axi_wvalid  (m_axi_wvalid),
  .s_axis_tready (s_axis_tready),
  .running       (running),
  .ctrl_done     (ctrl_done)
);

// File: bench/tb_wr_master.sv
`timescale 1ns/100ps

module tb_wr_master;

  localparam int NUM_CMDS    = 8;
  localparam int BEAT_BYTES  = 4;
  localparam int BURST_BEATS = 256;
  localparam int BURST_SIZE  = BEAT_BYTES * BURST_BEATS;
  localparam int MAX_OUT     = 8;
  localparam int DONE_WAIT   = 20000;

  logic        aclk;
  logic        areset;
  logic        ctrl_start;
  logic [31:0] ctrl_addr;
  logic [31:0] ctrl_size;
  logic        ctrl_done;
  logic        req_almost_full;
  logic        s_axis_tvalid;
  logic [31:0] s_axis_tdata;
  logic        s_axis_tready;
  logic        m_axi_awvalid;
  logic        m_axi_awready;
  logic [31:0] m_axi_awaddr;
  logic [7:0]  m_axi_awlen;
  logic        m_axi_wvalid;
  logic        m_axi_wready;
  logic [31:0] m_axi_wdata;
  logic [3:0]  m_axi_wstrb;
  logic        m_axi_wlast;
  logic        m_axi_bvalid;
  logic        m_axi_bready;

  // five words per command, see the pattern file
  logic [31:0] pat [0:NUM_CMDS*5-1];
  int          cum_bursts [NUM_CMDS];
  int          cum_beats [NUM_CMDS];

  // slave model state
  int aw_total;
  int aw_cmd;
  int aw_in_cmd;
  int w_total;
  int w_cmd;
  int w_in_cmd;
  int wlast_total;
  int w_started;
  int b_total;
  int b_sent;
  int b_delay;
  int done_cnt;
  int stream_next;
  bit new_burst;
  bit beat_taken;
  bit af_seen;

  wr_master_top dut_i (.*);

  always #10 aclk = ~aclk;

  task automatic stop_on_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopping after first error");
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1, "stopping after timeout");
  endtask

  function automatic int cmd_beats(input int idx);
    return (pat[idx*5+1] + BEAT_BYTES - 1) / BEAT_BYTES;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // slave monitor, samples everything on the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (!areset) begin
      if (req_almost_full) begin
        af_seen = 1'b1;
      end
      // responses are always accepted
      assert (m_axi_bready)
        else stop_on_error("bready low");
      // an address shows only once its burst has offered data
      if (m_axi_awvalid) begin
        assert (aw_total < w_started)
          else stop_on_error("address raised before its first data beat");
      end
      // address phase
      if (m_axi_awvalid && m_axi_awready) begin
        assert (m_axi_awaddr == pat[aw_cmd*5] + aw_in_cmd * BURST_SIZE)
          else stop_on_error($sformatf("awaddr %h, burst %0d of command %0d",
                                       m_axi_awaddr, aw_in_cmd, aw_cmd));
        if (aw_in_cmd == pat[aw_cmd*5+2] - 1) begin
          assert (m_axi_awlen == pat[aw_cmd*5+3][7:0])
            else stop_on_error($sformatf("final awlen %h", m_axi_awlen));
          aw_cmd++;
          aw_in_cmd = 0;
        end else begin
          assert (m_axi_awlen == 8'(BURST_BEATS - 1))
            else stop_on_error($sformatf("full awlen %h", m_axi_awlen));
          aw_in_cmd++;
        end
        aw_total++;
        assert (aw_total - b_total <= MAX_OUT)
          else stop_on_error("too many bursts outstanding");
      end
      // first offered beat of each burst
      if (m_axi_wvalid && new_burst) begin
        w_started++;
        new_burst = 1'b0;
      end
      // data phase
      beat_taken = m_axi_wvalid && m_axi_wready;
      // no buffering, so the stream moves exactly with the data channel
      assert ((s_axis_tvalid && s_axis_tready) == beat_taken)
        else stop_on_error($sformatf("stream handshake %b, data handshake %b",
                                     s_axis_tvalid && s_axis_tready, beat_taken));
      if (beat_taken) begin
        assert (m_axi_wdata == 32'(w_total))
          else stop_on_error($sformatf("wdata %h, expected %h", m_axi_wdata, w_total));
        assert (m_axi_wlast == (((w_in_cmd + 1) % BURST_BEATS == 0) ||
                                (w_in_cmd == cmd_beats(w_cmd) - 1)))
          else stop_on_error($sformatf("wlast wrong on beat %0d", w_in_cmd));
        if (w_in_cmd == cmd_beats(w_cmd) - 1) begin
          assert (m_axi_wstrb == pat[w_cmd*5+4][3:0])
            else stop_on_error($sformatf("final wstrb %h", m_axi_wstrb));
          w_cmd++;
          w_in_cmd = 0;
        end else begin
          assert (m_axi_wstrb == 4'hf)
            else stop_on_error($sformatf("wstrb %h mid command", m_axi_wstrb));
          w_in_cmd++;
        end
        if (m_axi_wlast) begin
          wlast_total++;
          new_burst = 1'b1;
        end
        w_total++;
        stream_next++;
      end
      if (m_axi_bvalid) begin
        b_total++;
      end
      // completion in order with all bursts and beats accounted for
      if (ctrl_done) begin
        assert (done_cnt < NUM_CMDS)
          else stop_on_error("extra ctrl_done");
        assert (aw_total == cum_bursts[done_cnt] && wlast_total == cum_bursts[done_cnt] &&
                w_total == cum_beats[done_cnt])
          else stop_on_error($sformatf("command %0d done with %0d bursts, %0d beats",
                                       done_cnt, aw_total, w_total));
        done_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // slave and stream drivers, just after the edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    #2;
    if (!areset) begin
      m_axi_awready = ($urandom % 4) != 0;
      m_axi_wready  = ($urandom % 4) != 0;
      // stream holds an offered beat until it is taken
      if (!s_axis_tvalid || beat_taken) begin
        s_axis_tvalid = ($urandom % 4) != 0;
        s_axis_tdata  = 32'(stream_next);
      end
      // one response per burst whose address and last beat were both seen
      // held back while the command still has addresses to issue,
      // until the outstanding limit is reached
      if (m_axi_bvalid) begin
        m_axi_bvalid = 1'b0;
      end else if (b_delay > 0) begin
        b_delay--;
      end else if (b_sent < aw_total && b_sent < wlast_total &&
                   (aw_in_cmd == 0 || aw_total - b_sent >= MAX_OUT)) begin
        m_axi_bvalid = 1'b1;
        b_sent++;
        b_delay = $urandom % 4;
      end
    end
  end

  initial begin
    int seed_dummy;
    int acc_b;
    int acc_w;
    int waited;
    seed_dummy = $urandom(32'haa4da2c7);
    aclk = 1'b0;
    areset = 1'b1;
    ctrl_start = 1'b0;
    ctrl_addr = '0;
    ctrl_size = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata = '0;
    m_axi_awready = 1'b0;
    m_axi_wready = 1'b0;
    m_axi_bvalid = 1'b0;
    {aw_total, aw_cmd, aw_in_cmd, w_total, w_cmd, w_in_cmd} = '0;
    {wlast_total, w_started, b_total, b_sent, b_delay, done_cnt} = '0;
    stream_next = 0;
    new_burst = 1'b1;
    beat_taken = 1'b0;
    af_seen = 1'b0;
    $readmemh("bench/wr_master_patterns.txt", pat);
    acc_b = 0;
    acc_w = 0;
    for (int i = 0; i < NUM_CMDS; i++) begin
      acc_b += pat[i*5+2];
      acc_w += cmd_beats(i);
      cum_bursts[i] = acc_b;
      cum_beats[i] = acc_w;
    end
    repeat (10) @(posedge aclk);
    #2 areset = 1'b0;
    // queue every command back to back
    for (int i = 0; i < NUM_CMDS; i++) begin
      @(posedge aclk);
      #2;
      ctrl_start = 1'b1;
      ctrl_addr = pat[i*5];
      ctrl_size = pat[i*5+1];
    end
    @(posedge aclk);
    #2 ctrl_start = 1'b0;
    for (int i = 0; i < NUM_CMDS; i++) begin
      waited = 0;
      while (done_cnt <= i && waited < DONE_WAIT) begin
        @(posedge aclk);
        waited++;
      end
      if (done_cnt <= i) begin
        stop_on_timeout($sformatf("ctrl_done of command %0d", i));
      end
    end
    repeat (4) @(posedge aclk);
    assert (af_seen)
      else stop_on_error("req_almost_full never rose");
    assert (!req_almost_full)
      else stop_on_error("req_almost_full still high after drain");
    assert (done_cnt == NUM_CMDS && b_total == cum_bursts[NUM_CMDS-1])
      else stop_on_error("response or done count off at end");
    $display("TEST OK");
    $finish;
  end

endmodule

// File: bench/wr_master_patterns.txt
// one command per line, all fields hex
// address  size  expected_bursts  expected_final_awlen  expected_final_wstrb
00001000 00000400 00000001 000000ff 0000000f
00002000 00000401 00000002 00000000 00000001
00010000 0000000a 00000001 00000002 00000003
00020000 00001000 00000004 000000ff 0000000f
00003000 00000803 00000003 00000000 00000007
00040000 00000004 00000001 00000000 0000000f
00005000 000002f6 00000001 000000bd 00000003
00100000 00002400 00000009 000000ff 0000000f

// File: compile.f
src/wm_pkg.sv
src/wm_counter.sv
src/cmd_queue.sv
src/xfer_control.sv
src/aw_channel.sv
src/w_channel.sv
src/wr_master_top.sv
bench/wr_master_asserts.sv
bench/tb_wr_master.sv

// File: run_sim.sh
#!/bin/sh
# build and run the write master testbench with Verilator

verilator --binary --timing --assert -f compile.f --top-module tb_wr_master \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "build or simulation aborted, see build.log and sim.log"; exit 1; }

grep -q "TEST FAILED" sim.log \
  && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
